// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := raystore_tb
FILELIST  := raystore.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/pipe_valid_stall.sv
module pipe_valid_stall #(
	parameter type payload_t = logic,
	parameter int  depth     = 2
) (
	input  logic          clk,
	input  logic          reset,

	input  logic          us_valid,
	input  payload_t      us_data,
	output logic          us_stall,

	output logic          ds_valid,
	output payload_t      ds_data,

	input  rt_pkg::cnt_t  num_left_in_fifo
);

	// one valid bit and one payload per stage
	logic [depth-1:0] valid_q;
	payload_t         data_q [depth];

	logic             accept;
	rt_pkg::cnt_t     in_flight;

	assign accept = us_valid & ~us_stall;

	// items already on their way to the fifo
	always_comb begin
		in_flight = '0;
		for (int i = 0; i < depth; i++) begin
			in_flight = in_flight + rt_pkg::cnt_t'(valid_q[i]);
		end
	end

	// every item in the pipe already owns a fifo slot
	assign us_stall = (in_flight >= num_left_in_fifo);

	// valid bits advance every cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= accept;
			for (int i = 1; i < depth; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// payload follows its valid bit
	always_ff @(posedge clk) begin
		data_q[0] <= us_data;
		for (int i = 1; i < depth; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	assign ds_valid = valid_q[depth-1];
	assign ds_data  = data_q[depth-1];

	// an item leaving the pipe always finds room
	a_credit_held: assert property (
		@(posedge clk) disable iff (reset)
		ds_valid |-> (num_left_in_fifo != '0)
	) else $error("pipe_valid_stall: item delivered with no free fifo slot");

endmodule: pipe_valid_stall

// File: logic/ray_bram.sv
module ray_bram (
	input  logic               clk,
	input  logic               reset,

	input  logic               we,
	input  rt_pkg::ray_id_t    waddr,
	input  rt_pkg::ray_vec_t   wdata,

	input  rt_pkg::ray_id_t    raddr,
	output rt_pkg::ray_vec_t   rd_data
);

	rt_pkg::ray_vec_t mem [rt_pkg::ray_depth];

	// first read stage
	rt_pkg::ray_id_t  raddr_q;

	// write port and address register
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		raddr_q <= raddr;
	end

	// second read stage, registered output
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_data <= '0;
		end else begin
			rd_data <= mem[raddr_q];
		end
	end

endmodule: ray_bram

// File: logic/raystore.sv
module raystore (
	input  logic              clk,
	input  logic              reset,

	// read requests
	input  logic              us_valid,
	input  rt_pkg::sb_t       us_sb_data,
	input  rt_pkg::ray_id_t   raddr,
	output logic              us_stall,

	// write port
	input  logic              we,
	input  rt_pkg::ray_vec_t  wdata,
	input  rt_pkg::ray_id_t   waddr,

	// results
	output logic              ds_valid,
	output rt_pkg::sb_t       ds_sb_data,
	output rt_pkg::ray_vec_t  ds_rd_data,
	input  logic              ds_stall
);

	// delay pipe
	logic                  pvs_ds_valid;
	rt_pkg::sb_t           pvs_ds_data;

	// memory
	rt_pkg::ray_vec_t      bram_rd_data;

	// output fifo
	logic                  fifo_we;
	logic                  fifo_re;
	logic                  fifo_empty;
	rt_pkg::cnt_t          num_left_in_fifo;
	rt_pkg::rs_fifo_data_t fifo_data_in;
	rt_pkg::rs_fifo_data_t fifo_data_out;

	// tag and ray meet at the fifo input
	assign fifo_data_in.sb_data = pvs_ds_data;
	assign fifo_data_in.rd_data = bram_rd_data;

	assign fifo_we = pvs_ds_valid;
	assign fifo_re = ~fifo_empty & ~ds_stall;

	assign ds_valid   = ~fifo_empty;
	assign ds_sb_data = fifo_data_out.sb_data;
	assign ds_rd_data = fifo_data_out.rd_data;

	// tag delay matches the memory read latency
	pipe_valid_stall #(
		.payload_t (rt_pkg::sb_t),
		.depth     (rt_pkg::rs_read_latency)
	) pvs (
		.clk,
		.reset,
		.us_valid,
		.us_data          (us_sb_data),
		.us_stall,
		.ds_valid         (pvs_ds_valid),
		.ds_data          (pvs_ds_data),
		.num_left_in_fifo
	);

	ray_bram bram (
		.clk,
		.reset,
		.we,
		.waddr,
		.wdata,
		.raddr,
		.rd_data (bram_rd_data)
	);

	stall_fifo #(
		.payload_t (rt_pkg::rs_fifo_data_t),
		.depth     (rt_pkg::rs_fifo_depth)
	) rs_fifo (
		.clk,
		.reset,
		.data_in          (fifo_data_in),
		.we               (fifo_we),
		.re               (fifo_re),
		.data_out         (fifo_data_out),
		.empty            (fifo_empty),
		.num_left_in_fifo
	);

	// no forwarding, same-id read and write is illegal
	a_no_rw_collision: assert property (
		@(posedge clk) disable iff (reset)
		!(we && us_valid && !us_stall && (raddr == waddr))
	) else $error("raystore: read and write to ray id %0d in one cycle", raddr);

	// a stalled result stays put
	a_ds_hold: assert property (
		@(posedge clk) disable iff (reset)
		(ds_valid && ds_stall) |=> (ds_valid && $stable(ds_sb_data) && $stable(ds_rd_data))
	) else $error("raystore: output changed while stalled");

endmodule: raystore

// File: logic/rt_pkg.sv
package rt_pkg;

	// ray store sizing
	localparam int ray_depth = 512;
	localparam int ray_id_w  = 9;
	localparam int sb_w      = 8;
	localparam int coord_w   = 32;

	// read pipeline sizing
	localparam int rs_fifo_depth   = 3;
	localparam int rs_read_latency = 2;

	// index into the ray memory
	typedef logic [ray_id_w-1:0] ray_id_t;

	// fixed point coordinate
	typedef logic [coord_w-1:0] coord_t;

	// origin then direction, 192 bits
	typedef struct packed {
		coord_t orig_x;
		coord_t orig_y;
		coord_t orig_z;
		coord_t dir_x;
		coord_t dir_y;
		coord_t dir_z;
	} ray_vec_t;

	// tag carried alongside each read request
	typedef logic [sb_w-1:0] sb_t;

	// one output fifo entry
	typedef struct packed {
		sb_t      sb_data;
		ray_vec_t rd_data;
	} rs_fifo_data_t;

	// free slots or items in flight
	typedef logic [1:0] cnt_t;

endpackage: rt_pkg

// File: logic/stall_fifo.sv
module stall_fifo #(
	parameter type payload_t = logic,
	parameter int  depth     = 3
) (
	input  logic          clk,
	input  logic          reset,

	input  payload_t      data_in,
	input  logic          we,
	input  logic          re,

	output payload_t      data_out,
	output logic          empty,
	output rt_pkg::cnt_t  num_left_in_fifo
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int occ_w = $clog2(depth + 1);

	payload_t          mem [depth];

	logic [ptr_w-1:0]  rd_ptr;
	logic [ptr_w-1:0]  wr_ptr;
	logic [occ_w-1:0]  occupancy;
	logic              full;

	assign empty = (occupancy == '0);
	assign full  = (occupancy == occ_w'(depth));

	assign num_left_in_fifo = rt_pkg::cnt_t'(occ_w'(depth) - occupancy);

	// show-ahead, head entry always on the output
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap at depth
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			if (we) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (re) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// occupancy, simultaneous read and write leaves it unchanged
	always_ff @(posedge clk) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			case ({we, re})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset)
		we |-> (!full || re)
	) else $error("stall_fifo: write while full");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (reset)
		re |-> !empty
	) else $error("stall_fifo: read while empty");

endmodule: stall_fifo

// File: raystore.f
+incdir+include
logic/rt_pkg.sv
logic/pipe_valid_stall.sv
logic/ray_bram.sv
logic/stall_fifo.sv
logic/raystore.sv
sim/raystore_tb.sv

// File: include/raystore_tb_tasks.svh
// reference copy of the ray memory and expected results in request order
rt_pkg::ray_vec_t      ref_mem [rt_pkg::ray_depth];
rt_pkg::rs_fifo_data_t exp_q [$];

int               errors         = 0;
int               accepted_count = 0;
int               consumed_count = 0;
rt_pkg::sb_t      last_sb;
rt_pkg::ray_vec_t last_ray;

task automatic log_error(input string text);
	errors++;
	$display("%s", text);
endtask

// every coordinate carries the whole id
function automatic rt_pkg::ray_vec_t fill_ray(input rt_pkg::ray_id_t id);
	rt_pkg::ray_vec_t r;
	r.orig_x = {4'h1, 3'b000, id, 7'h00, id};
	r.orig_y = {4'h2, 3'b001, id, 7'h11, id};
	r.orig_z = {4'h3, 3'b010, id, 7'h22, id};
	r.dir_x  = {4'h4, 3'b011, id, 7'h33, id};
	r.dir_y  = {4'h5, 3'b100, id, 7'h44, id};
	r.dir_z  = {4'h6, 3'b101, id, 7'h55, id};
	return r;
endfunction

function automatic rt_pkg::ray_vec_t random_ray();
	rt_pkg::ray_vec_t r;
	r.orig_x = $urandom();
	r.orig_y = $urandom();
	r.orig_z = $urandom();
	r.dir_x  = $urandom();
	r.dir_y  = $urandom();
	r.dir_z  = $urandom();
	return r;
endfunction

task automatic check_output();
	rt_pkg::rs_fifo_data_t want;
	assert (exp_q.size() > 0)
		else log_error($sformatf("output with tag %h at %0t has no outstanding request",
			ds_sb_data, $time));
	if (exp_q.size() > 0) begin
		want = exp_q.pop_front();
		assert (ds_sb_data === want.sb_data)
			else log_error($sformatf("mismatch at %0t: ds_sb_data got %h expected %h",
				$time, ds_sb_data, want.sb_data));
		assert (ds_rd_data === want.rd_data)
			else log_error($sformatf("mismatch at %0t: ds_rd_data got %h expected %h",
				$time, ds_rd_data, want.rd_data));
	end
	last_sb  = ds_sb_data;
	last_ray = ds_rd_data;
endtask

// one clock cycle with inputs changed on the falling edge
task automatic step(
	input  logic             valid,
	input  rt_pkg::sb_t      sb,
	input  rt_pkg::ray_id_t  rid,
	input  logic             wr,
	input  rt_pkg::ray_id_t  wid,
	input  rt_pkg::ray_vec_t wray,
	input  logic             stall,
	output logic             accepted,
	output logic             consumed
);
	rt_pkg::rs_fifo_data_t item;
	@(negedge clk);
	us_valid   = valid;
	us_sb_data = sb;
	raddr      = rid;
	we         = wr;
	waddr      = wid;
	wdata      = wray;
	ds_stall   = stall;
	// us_stall and ds_valid come from registers only
	accepted = valid && !us_stall;
	consumed = ds_valid && !stall;
	if (accepted) begin
		item.sb_data = sb;
		item.rd_data = ref_mem[rid];
		exp_q.push_back(item);
		accepted_count++;
	end
	if (wr) begin
		ref_mem[wid] = wray;
	end
	if (consumed) begin
		consumed_count++;
		check_output();
	end
endtask

task automatic preload_memory();
	logic a;
	logic c;
	for (int i = 0; i < rt_pkg::ray_depth; i++) begin
		step(1'b0, '0, '0, 1'b1, rt_pkg::ray_id_t'(i), fill_ray(rt_pkg::ray_id_t'(i)),
			1'b0, a, c);
	end
endtask

// empty the pipeline and watch a few more cycles for strays
task automatic drain();
	logic a;
	logic c;
	int   quiet;
	quiet = 0;
	while (exp_q.size() > 0 || quiet < 4) begin
		step(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, a, c);
		if (exp_q.size() == 0) begin
			quiet++;
		end
	end
endtask

task automatic test_reset_state();
	assert (ds_valid === 1'b0)
		else log_error($sformatf("mismatch at %0t: ds_valid got %b expected 0", $time, ds_valid));
	assert (us_stall === 1'b0)
		else log_error($sformatf("mismatch at %0t: us_stall got %b expected 0", $time, us_stall));
endtask

task automatic test_single_read();
	rt_pkg::ray_vec_t ray;
	logic             a;
	logic             c;
	logic [2:0]       seen;
	ray = random_ray();
	drain();
	step(1'b0, '0, '0, 1'b1, 9'd5, ray, 1'b0, a, c);
	step(1'b1, 8'ha5, 9'd5, 1'b0, '0, '0, 1'b0, a, c);
	assert (a) else log_error($sformatf("read of ray 5 was not accepted at %0t", $time));
	for (int i = 0; i < 3; i++) begin
		step(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, a, c);
		seen[i] = c;
	end
	// low, low, then high on the third cycle
	assert (seen === 3'b100)
		else log_error($sformatf("mismatch at %0t: ds_valid timing got %b expected 100",
			$time, seen));
	assert (last_sb === 8'ha5)
		else log_error($sformatf("mismatch at %0t: ds_sb_data got %h expected a5", $time, last_sb));
	assert (last_ray === ray)
		else log_error($sformatf("mismatch at %0t: ds_rd_data got %h expected %h",
			$time, last_ray, ray));
	drain();
endtask

task automatic test_overwrite();
	rt_pkg::ray_vec_t ray_a;
	rt_pkg::ray_vec_t ray_b;
	logic             a;
	logic             c;
	ray_a = random_ray();
	ray_b = random_ray();
	drain();
	step(1'b0, '0, '0, 1'b1, 9'd7, ray_a, 1'b0, a, c);
	step(1'b0, '0, '0, 1'b1, 9'd7, ray_b, 1'b0, a, c);
	step(1'b1, 8'h3c, 9'd7, 1'b0, '0, '0, 1'b0, a, c);
	assert (a) else log_error($sformatf("read of ray 7 was not accepted at %0t", $time));
	drain();
	assert (last_sb === 8'h3c)
		else log_error($sformatf("mismatch at %0t: ds_sb_data got %h expected 3c", $time, last_sb));
	assert (last_ray === ray_b)
		else log_error($sformatf("mismatch at %0t: ds_rd_data got %h expected %h",
			$time, last_ray, ray_b));
endtask

task automatic test_backpressure();
	logic a;
	logic c;
	int   taken;
	int   start_con;
	drain();
	taken     = 0;
	start_con = consumed_count;
	// same request is held until it is taken
	for (int i = 0; i < 12; i++) begin
		step(1'b1, rt_pkg::sb_t'(8'h40 + taken), rt_pkg::ray_id_t'(100 + taken),
			1'b0, '0, '0, 1'b1, a, c);
		if (a) begin
			taken++;
		end
	end
	assert (taken == 3)
		else log_error($sformatf("mismatch at %0t: accepted requests got %0d expected 3",
			$time, taken));
	assert (us_stall === 1'b1)
		else log_error($sformatf("mismatch at %0t: us_stall got %b expected 1", $time, us_stall));
	drain();
	assert (consumed_count - start_con == 3)
		else log_error($sformatf("mismatch at %0t: delivered results got %0d expected 3",
			$time, consumed_count - start_con));
endtask

task automatic test_random_stream();
	logic            a;
	logic            c;
	logic            have_req;
	logic            wr;
	logic            stall;
	rt_pkg::sb_t     sb;
	rt_pkg::ray_id_t rid;
	rt_pkg::ray_id_t wid;
	int              issued;
	int              start_con;
	drain();
	start_con = consumed_count;
	issued    = 0;
	have_req  = 1'b0;
	sb        = '0;
	rid       = '0;
	while (issued < 300) begin
		if (!have_req && ($urandom_range(3) != 0)) begin
			sb       = rt_pkg::sb_t'($urandom());
			rid      = rt_pkg::ray_id_t'($urandom());
			have_req = 1'b1;
		end
		wr  = ($urandom_range(3) == 0);
		wid = rt_pkg::ray_id_t'($urandom());
		// never write the id being read
		if (wid == rid) begin
			wid = wid + rt_pkg::ray_id_t'(1);
		end
		stall = ($urandom_range(9) < 3);
		step(have_req, sb, rid, wr, wid, random_ray(), stall, a, c);
		if (a) begin
			issued++;
			have_req = 1'b0;
		end
	end
	drain();
	assert (consumed_count - start_con == 300)
		else log_error($sformatf("mismatch at %0t: delivered results got %0d expected 300",
			$time, consumed_count - start_con));
endtask

// File: sim/raystore_tb.sv
module raystore_tb;

	// reset plus preload plus all tests come to well under half of this
	localparam int timeout_cycles = 4000;
	localparam int reset_cycles   = 16;

	logic              clk;
	logic              reset;
	logic              us_valid;
	rt_pkg::sb_t       us_sb_data;
	rt_pkg::ray_id_t   raddr;
	logic              us_stall;
	logic              we;
	rt_pkg::ray_vec_t  wdata;
	rt_pkg::ray_id_t   waddr;
	logic              ds_valid;
	rt_pkg::sb_t       ds_sb_data;
	rt_pkg::ray_vec_t  ds_rd_data;
	logic              ds_stall;
	int                cycles;

	`include "raystore_tb_tasks.svh"

	raystore raystore_i (
		.clk,
		.reset,
		.us_valid,
		.us_sb_data,
		.raddr,
		.us_stall,
		.we,
		.wdata,
		.waddr,
		.ds_valid,
		.ds_sb_data,
		.ds_rd_data,
		.ds_stall
	);

	always #5 clk = ~clk;

	// run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles with %0d errors", cycles, errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(25));
		clk        = 1'b0;
		reset      = 1'b1;
		cycles     = 0;
		us_valid   = 1'b0;
		us_sb_data = '0;
		raddr      = '0;
		we         = 1'b0;
		wdata      = '0;
		waddr      = '0;
		ds_stall   = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_reset_state();
		preload_memory();
		test_single_read();
		test_overwrite();
		test_backpressure();
		test_random_stream();

		$display("errors: %0d, accepted: %0d, consumed: %0d",
			errors, accepted_count, consumed_count);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule: raystore_tb
